// File: source/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] INST_NOP  = 32'h0000_0013; // addi x0, x0, 0.
    localparam logic [XLEN-1:0] REGPC_NOP = '1;            // empty slot marker.
    localparam logic [XLEN-1:0] RESET_PC  = '0;

    localparam int IMEM_WORDS   = 256;
    localparam int IMEM_AW      = $clog2(IMEM_WORDS);
    localparam int IMEM_LATENCY = 2;                       // accept to valid.
    localparam int IMEM_LAT_W   = $clog2(IMEM_LATENCY + 1);

    localparam logic [6:0] OPC_JAL = 7'b110_1111;

    // fetch request machine
    localparam logic ST_WAIT_READY = 1'b0;
    localparam logic ST_WAIT_VALID = 1'b1;

    // one instruction word, read as I-type or as J-type.
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j_view;
    } inst_word_u;

endpackage

// File: source/inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       mem_start,
    input  logic [fetch_pkg::XLEN-1:0] mem_addr,
    output logic                       mem_ready,
    output logic [fetch_pkg::XLEN-1:0] mem_data,
    output logic                       mem_data_valid,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [fetch_pkg::XLEN-1:0] paddr,
    input  logic [fetch_pkg::XLEN-1:0] pwdata,
    output logic [fetch_pkg::XLEN-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    import fetch_pkg::*;

    logic [XLEN-1:0]       mem [IMEM_WORDS];
    logic [IMEM_LAT_W-1:0] lat_cnt;
    logic [XLEN-1:0]       rd_word;
    logic [IMEM_AW-1:0]    fetch_idx;
    logic [IMEM_AW-1:0]    apb_idx;
    logic                  accept;
    logic                  apb_access;
    logic                  apb_in_range;

    assign fetch_idx = mem_addr[IMEM_AW+1:2];
    assign apb_idx   = paddr[IMEM_AW+1:2];

    // last count before idle is the data cycle.
    assign mem_data_valid = (lat_cnt == IMEM_LAT_W'(1));
    assign mem_ready      = run && ((lat_cnt == '0) || mem_data_valid);
    assign accept         = mem_start && mem_ready;
    assign mem_data       = rd_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (accept) begin
            lat_cnt <= IMEM_LAT_W'(IMEM_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - IMEM_LAT_W'(1);
        end
    end

    assign apb_access   = psel && penable;
    assign apb_in_range = {2'b00, paddr[XLEN-1:2]} < XLEN'(IMEM_WORDS);

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_word <= mem[fetch_idx]; // held until valid.
        end
        if (apb_access && pwrite && apb_in_range) begin
            mem[apb_idx] <= pwdata;
        end
    end

    // no wait states on the load port.
    assign pready  = 1'b1;
    assign pslverr = apb_access && !apb_in_range;
    assign prdata  = (psel && apb_in_range) ? mem[apb_idx] : '0;

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc,
    output logic                       mem_start,
    output logic [fetch_pkg::XLEN-1:0] mem_addr,
    input  logic                       mem_ready,
    input  logic [fetch_pkg::XLEN-1:0] mem_data,
    input  logic                       mem_data_valid,
    output logic [fetch_pkg::XLEN-1:0] id_pc,
    output logic [fetch_pkg::XLEN-1:0] id_inst
);

    import fetch_pkg::*;

    logic            state;
    logic            fetched;   // save buffer holds a word.
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next4;
    logic [XLEN-1:0] saved_pc;
    logic [XLEN-1:0] saved_inst;
    logic [XLEN-1:0] out_pc;
    logic [XLEN-1:0] out_inst;
    logic            got;
    logic            have;
    logic            want;
    logic            out_valid;
    logic            release_slot;

    // pc is the address in flight, or the next one to request.
    assign pc_next4 = pc + XLEN'(4);

    assign got  = (state == ST_WAIT_VALID) && !fetched && mem_data_valid;
    assign have = (state == ST_WAIT_VALID) && fetched;

    always_comb begin
        if (state == ST_WAIT_READY) begin
            want = 1'b1;
        end else if (redirect) begin
            want = got || have; // in-flight word is dropped.
        end else begin
            want = (got || have) && !stall;
        end
    end

    assign mem_start = want && mem_ready;
    assign mem_addr  = redirect ? redirect_pc :
                       got      ? pc_next4    : pc;

    // a word leaves toward decode only when nothing holds it back.
    assign out_valid = !stall && !redirect && (got || have);
    assign out_pc    = got ? pc : saved_pc;
    assign out_inst  = got ? mem_data : saved_inst;

    assign release_slot = redirect || ((got || have) && !stall);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_WAIT_READY;
            fetched <= 1'b0;
            pc      <= RESET_PC;
            id_pc   <= REGPC_NOP;
            id_inst <= INST_NOP;
        end else begin
            id_pc   <= out_valid ? out_pc : REGPC_NOP;
            id_inst <= out_valid ? out_inst : INST_NOP;

            if (redirect) begin
                pc <= redirect_pc;
            end else if (got) begin
                pc <= pc_next4;
            end

            if (state == ST_WAIT_READY) begin
                if (mem_start) begin
                    state   <= ST_WAIT_VALID;
                    fetched <= 1'b0;
                end
            end else if (release_slot) begin
                fetched <= 1'b0;
                if (!mem_start) begin
                    state <= ST_WAIT_READY; // memory not ready yet.
                end
            end else if (got) begin
                fetched <= 1'b1; // arrived under stall.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (got && stall && !redirect) begin
            saved_pc   <= pc;
            saved_inst <= mem_data;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic [fetch_pkg::XLEN-1:0] id_pc,
    input  logic [fetch_pkg::XLEN-1:0] id_inst,
    output logic                       redirect,
    output logic [fetch_pkg::XLEN-1:0] redirect_pc,
    output logic                       retire_valid,
    output logic [fetch_pkg::XLEN-1:0] retire_pc,
    output logic [fetch_pkg::XLEN-1:0] retire_inst,
    output logic [4:0]                 retire_rd,
    output logic [fetch_pkg::XLEN-1:0] retire_imm
);

    import fetch_pkg::*;

    inst_word_u      word;
    logic            is_jal;
    logic [XLEN-1:0] j_off;
    logic [XLEN-1:0] i_imm;

    assign word = id_inst;

    assign is_jal = (word.j_view.opcode == OPC_JAL);

    // J-type offset, bit 0 always zero.
    assign j_off = {{11{word.j_view.imm20}},
                    word.j_view.imm20,
                    word.j_view.imm19_12,
                    word.j_view.imm11,
                    word.j_view.imm10_1,
                    1'b0};

    assign i_imm = {{(XLEN - 12){word.i_view.imm12[11]}}, word.i_view.imm12};

    assign retire_valid = (id_pc != REGPC_NOP);
    assign retire_pc    = id_pc;
    assign retire_inst  = id_inst;
    assign retire_rd    = word.i_view.rd;
    assign retire_imm   = is_jal ? j_off : i_imm;

    // one cycle only, fetch bubbles the slot behind it.
    assign redirect    = retire_valid && is_jal;
    assign redirect_pc = id_pc + j_off;

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       stall,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [fetch_pkg::XLEN-1:0] paddr,
    input  logic [fetch_pkg::XLEN-1:0] pwdata,
    output logic [fetch_pkg::XLEN-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       retire_valid,
    output logic [fetch_pkg::XLEN-1:0] retire_pc,
    output logic [fetch_pkg::XLEN-1:0] retire_inst,
    output logic [4:0]                 retire_rd,
    output logic [fetch_pkg::XLEN-1:0] retire_imm
);

    import fetch_pkg::*;

    logic            mem_start;
    logic [XLEN-1:0] mem_addr;
    logic            mem_ready;
    logic [XLEN-1:0] mem_data;
    logic            mem_data_valid;
    logic [XLEN-1:0] id_pc;
    logic [XLEN-1:0] id_inst;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    inst_mem u_inst_mem (
        .clk(clk), .rst_n(rst_n), .run(run),
        .mem_start(mem_start), .mem_addr(mem_addr), .mem_ready(mem_ready),
        .mem_data(mem_data), .mem_data_valid(mem_data_valid),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    fetch_stage u_fetch_stage (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_start(mem_start), .mem_addr(mem_addr), .mem_ready(mem_ready),
        .mem_data(mem_data), .mem_data_valid(mem_data_valid),
        .id_pc(id_pc), .id_inst(id_inst)
    );

    decode_stage u_decode_stage (
        .id_pc(id_pc), .id_inst(id_inst),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_inst(retire_inst), .retire_rd(retire_rd), .retire_imm(retire_imm)
    );

endmodule

// File: dv/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       stall,
    input logic                       mem_start,
    input logic                       mem_ready,
    input logic                       mem_data_valid,
    input logic [fetch_pkg::XLEN-1:0] id_pc,
    input logic [fetch_pkg::XLEN-1:0] id_inst
);

    import fetch_pkg::*;

    int fail_count = 0;

    // no second request while one is in flight.
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_start && mem_ready) |=> (!mem_ready) [*IMEM_LATENCY-1])
        else begin
            $error("mem_ready high while a request is in flight");
            fail_count++;
        end

    // data comes back exactly one latency after acceptance.
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_valid |-> $past(mem_start && mem_ready, IMEM_LATENCY))
        else begin
            $error("mem_data_valid without a matching accepted request");
            fail_count++;
        end

    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (id_pc == REGPC_NOP) && (id_inst == INST_NOP))
        else begin
            $error("id slot not empty in the cycle after stall");
            fail_count++;
        end

endmodule

bind fetch_stage fetch_chk u_fetch_chk (
    .clk(clk), .rst_n(rst_n), .stall(stall),
    .mem_start(mem_start), .mem_ready(mem_ready), .mem_data_valid(mem_data_valid),
    .id_pc(id_pc), .id_inst(id_inst)
);

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int TOTAL_RETIRES   = 4 + 16 + 28 + 24;
    localparam int WATCHDOG_CYCLES = TOTAL_RETIRES * 4 * IMEM_LATENCY + 2000;

    logic            clk;
    logic            rst_n;
    logic            run;
    logic            stall;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] paddr;
    logic [XLEN-1:0] pwdata;
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
    logic            retire_valid;
    logic [XLEN-1:0] retire_pc;
    logic [XLEN-1:0] retire_inst;
    logic [4:0]      retire_rd;
    logic [XLEN-1:0] retire_imm;

    logic [XLEN-1:0] prog [IMEM_WORDS]; // mirror of the loaded program.
    logic [XLEN-1:0] got_pc [$];
    logic [XLEN-1:0] got_inst [$];
    logic [4:0]      got_rd [$];
    logic [XLEN-1:0] got_imm [$];
    logic            stall_q;
    int              seed;

    fetch_top DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [XLEN-1:0] fill_word(input int idx);
        logic [7:0] i;
        i = idx[7:0];
        return {i, 4'hc, i[4:0], 3'b000, i[7:3], 7'h13}; // addi with fields from the index.
    endfunction

    function automatic logic [XLEN-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // immediate as the ISA defines it for this opcode.
    function automatic logic [XLEN-1:0] expected_imm(input logic [XLEN-1:0] inst);
        if (inst[6:0] == 7'h6f) begin
            return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic apb_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                             output logic err);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk) err = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data,
                            output logic err);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        data = prdata;
        check_value("pready", 1, pready);
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reset_dut(input logic run_val);
        rst_n = 1'b0;
        run = run_val;
        stall = 1'b0;
        got_pc.delete();
        got_inst.delete();
        got_rd.delete();
        got_imm.delete();
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic wait_retires(input int n);
        while (got_pc.size() < n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // walks the program from RESET_PC and compares each retire in order.
    task automatic compare_with_model(input int n);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        pc = RESET_PC;
        for (int k = 0; k < n; k++) begin
            inst = prog[pc / 4];
            check_value("retire_pc", pc, got_pc[k]);
            check_value("retire_inst", inst, got_inst[k]);
            check_value("retire_rd", inst[11:7], got_rd[k]);
            check_value("retire_imm", expected_imm(inst), got_imm[k]);
            pc = (inst[6:0] == 7'h6f) ? pc + expected_imm(inst) : pc + 4;
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (DUT.u_fetch_stage.u_fetch_chk.fail_count != 0) begin
            $display("a bound assertion on the fetch interface failed at %0t ns", $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failure");
        end
        if (rst_n) begin
            if (stall_q) begin
                check_value("retire_valid after stall", 0, retire_valid);
            end
            if (retire_valid) begin
                got_pc.push_back(retire_pc);
                got_inst.push_back(retire_inst);
                got_rd.push_back(retire_rd);
                got_imm.push_back(retire_imm);
            end
        end
        stall_q = stall;
    end

    task automatic load_program();
        logic            err;
        logic [XLEN-1:0] data;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = fill_word(i);
            apb_write(i * 4, prog[i], err);
            check_value("pslverr", 0, err);
        end
        for (int i = 0; i < IMEM_WORDS; i += 17) begin
            apb_read(i * 4, data, err);
            check_value("prdata", prog[i], data);
            check_value("pslverr", 0, err);
        end
        apb_write(IMEM_WORDS * 4, 32'hdead_beef, err);
        check_value("pslverr", 1, err);
        apb_read(IMEM_WORDS * 4, data, err);
        check_value("pslverr", 1, err);
        check_value("prdata", 0, data);
        apb_read(32'h0001_0000, data, err);
        check_value("pslverr", 1, err);
        check_value("prdata", 0, data);
    endtask

    task automatic gate_fetch_on_run();
        reset_dut(1'b0);
        repeat (20) @(posedge clk);
        #2;
        check_value("retire count while run low", 0, got_pc.size());
        run = 1'b1;
        wait_retires(4);
        compare_with_model(4);
    endtask

    task automatic retire_straight_line();
        reset_dut(1'b1);
        wait_retires(16);
        compare_with_model(16);
    endtask

    task automatic apply_random_stall();
        logic [31:0] rnd;
        reset_dut(1'b1);
        while (got_pc.size() < 24) begin
            rnd = $random(seed);
            stall = rnd[0];
            @(posedge clk);
            #2;
        end
        stall = 1'b0;
        wait_retires(28);
        compare_with_model(28);
    endtask

    task automatic follow_jal_jumps();
        logic err;
        run = 1'b0;
        prog[5] = jal_word(5'd1, 21'd12);       // forward jump over words 6 and 7.
        prog[12] = jal_word(5'd2, -21'sd12);    // loop back to word 9.
        apb_write(5 * 4, prog[5], err);
        apb_write(12 * 4, prog[12], err);
        reset_dut(1'b1);
        wait_retires(24);
        compare_with_model(24);
        for (int k = 0; k < 24; k++) begin
            check_value("retire of a skipped word", 0, got_pc[k] == 24 || got_pc[k] == 28);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        stall = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        stall_q = 1'b0;
        seed = 32'hc301f12c;
        @(posedge clk);
        #2;
        reset_dut(1'b0);
        load_program();
        gate_fetch_on_run();
        retire_straight_line();
        apply_random_stall();
        follow_jal_jumps();
        if (DUT.u_fetch_stage.u_fetch_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failures detected");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: vlog.f
source/fetch_pkg.sv
source/inst_mem.sv
source/fetch_stage.sv
source/decode_stage.sv
source/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - source/fetch_pkg.sv
  - source/inst_mem.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/fetch_top.sv
  - target: test
    files:
      - dv/fetch_chk.sv
      - dv/fetch_tb.sv
